// File: src/perf_pkg.sv
`default_nettype none

package perf_pkg;

	// widths of the counters, the cycle timer and the record words
	parameter int cnt_w            = 12;
	parameter int cycle_w          = 32;
	parameter int word_w           = 32;
	parameter int words_per_record = 6;

	// one bit per watched cache event line
	typedef struct packed {
		logic l1i_read;
		logic l1i_miss;
		logic l1d_read;
		logic l1d_write;
		logic l1d_miss;
		logic l2_read;
		logic l2_write;
		logic l2_miss;
	} cache_events_t;

	// running count for each event line, same field order as the lines
	typedef struct packed {
		logic [cnt_w-1:0] l1i_read;
		logic [cnt_w-1:0] l1i_miss;
		logic [cnt_w-1:0] l1d_read;
		logic [cnt_w-1:0] l1d_write;
		logic [cnt_w-1:0] l1d_miss;
		logic [cnt_w-1:0] l2_read;
		logic [cnt_w-1:0] l2_write;
		logic [cnt_w-1:0] l2_miss;
	} event_counts_t;

	// tag byte at the top of each record word
	typedef logic [7:0] record_tag_t;

	// upper case letters mark access counts, lower case marks misses
	parameter record_tag_t tag_l1i_access = 8'h41;
	parameter record_tag_t tag_l1i_miss   = 8'h61;
	parameter record_tag_t tag_l1d_access = 8'h42;
	parameter record_tag_t tag_l1d_miss   = 8'h62;
	parameter record_tag_t tag_l2_access  = 8'h43;
	parameter record_tag_t tag_l2_miss    = 8'h63;

endpackage

`default_nettype wire

// File: src/event_counter_bank.sv
`default_nettype none

module event_counter_bank (
	input  logic                    clk,
	input  logic                    rstn,
	input  perf_pkg::cache_events_t events,
	output perf_pkg::event_counts_t counts
);

	localparam logic [perf_pkg::cnt_w-1:0] one = perf_pkg::cnt_w'(1);

	// line values seen at the previous edge
	perf_pkg::cache_events_t prev;

	// high for one edge when a line goes from low to high
	perf_pkg::cache_events_t rise;

	assign rise = events & ~prev;

	// history starts low, so a line already high out of reset counts once
	always_ff @(posedge clk) begin
		if (!rstn) begin
			prev <= '0;
		end else begin
			prev <= events;
		end
	end

	// one increment per rising edge, wraps at the counter width
	always_ff @(posedge clk) begin
		if (!rstn) begin
			counts <= '0;
		end else begin
			// instruction cache
			if (rise.l1i_read) begin
				counts.l1i_read <= counts.l1i_read + one;
			end
			if (rise.l1i_miss) begin
				counts.l1i_miss <= counts.l1i_miss + one;
			end

			// data cache
			if (rise.l1d_read) begin
				counts.l1d_read <= counts.l1d_read + one;
			end
			if (rise.l1d_write) begin
				counts.l1d_write <= counts.l1d_write + one;
			end
			if (rise.l1d_miss) begin
				counts.l1d_miss <= counts.l1d_miss + one;
			end

			// second level
			if (rise.l2_read) begin
				counts.l2_read <= counts.l2_read + one;
			end
			if (rise.l2_write) begin
				counts.l2_write <= counts.l2_write + one;
			end
			if (rise.l2_miss) begin
				counts.l2_miss <= counts.l2_miss + one;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/sample_timer.sv
`default_nettype none

module sample_timer #(
	parameter int unsigned SAMPLE_FIRST  = 500,
	parameter int unsigned SAMPLE_PERIOD = 1000,
	parameter int unsigned SAMPLE_COUNT  = 3
) (
	input  logic clk,
	input  logic rstn,
	output logic sample
);

	localparam int issued_w = $clog2(SAMPLE_COUNT + 1);

	logic [perf_pkg::cycle_w-1:0] cycle_cnt;
	logic [perf_pkg::cycle_w-1:0] target;
	logic [issued_w-1:0]          issued;
	logic                         done;

	// all programmed samples have gone out
	assign done = (issued == issued_w'(SAMPLE_COUNT));

	assign sample = !done && (cycle_cnt == target);

	// free running, counts every active edge
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cycle_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + perf_pkg::cycle_w'(1);
		end
	end

	// next sample point moves on by one period after each hit
	always_ff @(posedge clk) begin
		if (!rstn) begin
			target <= perf_pkg::cycle_w'(SAMPLE_FIRST);
			issued <= '0;
		end else if (sample) begin
			target <= target + perf_pkg::cycle_w'(SAMPLE_PERIOD);
			issued <= issued + issued_w'(1);
		end
	end

endmodule

`default_nettype wire

// File: src/record_serializer.sv
`default_nettype none

module record_serializer (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          sample,
	input  perf_pkg::event_counts_t       counts,
	output logic [perf_pkg::word_w-1:0]   data,
	output logic                          wr_en
);

	localparam int idx_w = $clog2(perf_pkg::words_per_record + 1);
	localparam int pad_w = perf_pkg::word_w - 16 - perf_pkg::cnt_w;

	localparam logic [idx_w-1:0] last_idx = idx_w'(perf_pkg::words_per_record);

	// the six values that go out in one record
	typedef struct packed {
		logic [perf_pkg::cnt_w-1:0] l1i_access;
		logic [perf_pkg::cnt_w-1:0] l1i_miss;
		logic [perf_pkg::cnt_w-1:0] l1d_access;
		logic [perf_pkg::cnt_w-1:0] l1d_miss;
		logic [perf_pkg::cnt_w-1:0] l2_access;
		logic [perf_pkg::cnt_w-1:0] l2_miss;
	} snap_t;

	snap_t            live;
	snap_t            snap;
	logic [idx_w-1:0] idx;

	// tag twice, zero pad, then the count
	function automatic logic [perf_pkg::word_w-1:0] pick_word(
		input snap_t            s,
		input logic [idx_w-1:0] i
	);
		perf_pkg::record_tag_t      tag;
		logic [perf_pkg::cnt_w-1:0] val;
		case (i)
			idx_w'(0): begin
				tag = perf_pkg::tag_l1i_access;
				val = s.l1i_access;
			end
			idx_w'(1): begin
				tag = perf_pkg::tag_l1i_miss;
				val = s.l1i_miss;
			end
			idx_w'(2): begin
				tag = perf_pkg::tag_l1d_access;
				val = s.l1d_access;
			end
			idx_w'(3): begin
				tag = perf_pkg::tag_l1d_miss;
				val = s.l1d_miss;
			end
			idx_w'(4): begin
				tag = perf_pkg::tag_l2_access;
				val = s.l2_access;
			end
			default: begin
				tag = perf_pkg::tag_l2_miss;
				val = s.l2_miss;
			end
		endcase
		return {tag, tag, {pad_w{1'b0}}, val};
	endfunction

	// access sums wrap at the counter width, same as the counters
	assign live.l1i_access = counts.l1i_read;
	assign live.l1i_miss   = counts.l1i_miss;
	assign live.l1d_access = counts.l1d_read + counts.l1d_write;
	assign live.l1d_miss   = counts.l1d_miss;
	assign live.l2_access  = counts.l2_read + counts.l2_write;
	assign live.l2_miss    = counts.l2_miss;

	// the six values as they stood before the sample edge
	always_ff @(posedge clk) begin
		if (sample) begin
			snap <= live;
		end
	end

	// first word leaves straight from the live counts at the sample edge,
	// the other five come from the snapshot
	always_ff @(posedge clk) begin
		if (!rstn) begin
			data  <= '0;
			wr_en <= 1'b0;
			idx   <= '0;
		end else if (sample) begin
			data  <= pick_word(live, idx_w'(0));
			wr_en <= 1'b1;
			idx   <= idx_w'(1);
		end else if (wr_en) begin
			if (idx == last_idx) begin
				wr_en <= 1'b0;
				idx   <= '0;
			end else begin
				data <= pick_word(snap, idx);
				idx  <= idx + idx_w'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: src/cache_perf_monitor.sv
`default_nettype none

module cache_perf_monitor #(
	parameter int unsigned SAMPLE_FIRST  = 500,
	parameter int unsigned SAMPLE_PERIOD = 1000,
	parameter int unsigned SAMPLE_COUNT  = 3
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  perf_pkg::cache_events_t     events,
	output logic [perf_pkg::word_w-1:0] data,
	output logic                        wr_en
);

	// running counts from the bank
	perf_pkg::event_counts_t counts;

	// one cycle pulse at each sample point
	logic sample;

	event_counter_bank u_bank (
		.clk    (clk),
		.rstn   (rstn),
		.events (events),
		.counts (counts)
	);

	// period must be longer than one record
	sample_timer #(
		.SAMPLE_FIRST  (SAMPLE_FIRST),
		.SAMPLE_PERIOD (SAMPLE_PERIOD),
		.SAMPLE_COUNT  (SAMPLE_COUNT)
	) u_timer (
		.clk    (clk),
		.rstn   (rstn),
		.sample (sample)
	);

	record_serializer u_ser (
		.clk    (clk),
		.rstn   (rstn),
		.sample (sample),
		.counts (counts),
		.data   (data),
		.wr_en  (wr_en)
	);

endmodule

`default_nettype wire

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference model of the monitor, included inside the testbench module
// line bits follow the packed struct: l1i_read at bit 7 down to l2_miss at bit 0
int unsigned model_cycle = 0;
logic [7:0]  model_prev  = '0;
logic [11:0] model_cnt [8];
int          words_left  = 0;
logic [31:0] exp_words [$];

// cycle values SAMPLE_FIRST + k * SAMPLE_PERIOD, k below SAMPLE_COUNT
function automatic bit is_sample_point(input int unsigned c);
	if (c < SAMPLE_FIRST) return 1'b0;
	if ((c - SAMPLE_FIRST) % SAMPLE_PERIOD != 0) return 1'b0;
	return ((c - SAMPLE_FIRST) / SAMPLE_PERIOD) < SAMPLE_COUNT;
endfunction

// tag byte twice, a zero nibble, then the 12 bit count
function automatic logic [31:0] make_word(input logic [7:0] tag, input logic [11:0] val);
	return {tag, tag, 4'h0, val};
endfunction

task automatic reset_model();
	model_cycle = 0;
	model_prev  = '0;
	words_left  = 0;
	foreach (model_cnt[i]) model_cnt[i] = '0;
endtask

// six words in output order, sums wrap at 12 bits
task automatic push_record();
	logic [11:0] l1d_access;
	logic [11:0] l2_access;
	l1d_access = model_cnt[5] + model_cnt[4];
	l2_access  = model_cnt[2] + model_cnt[1];
	exp_words.push_back(make_word(8'h41, model_cnt[7]));
	exp_words.push_back(make_word(8'h61, model_cnt[6]));
	exp_words.push_back(make_word(8'h42, l1d_access));
	exp_words.push_back(make_word(8'h62, model_cnt[3]));
	exp_words.push_back(make_word(8'h43, l2_access));
	exp_words.push_back(make_word(8'h63, model_cnt[0]));
endtask

// snapshot first, then count the rising lines seen at this edge
task automatic take_edge(input logic [7:0] lines);
	if (words_left > 0) words_left = words_left - 1;
	if (is_sample_point(model_cycle)) begin
		push_record();
		words_left = 6;
	end
	for (int i = 0; i < 8; i++) begin
		if (lines[i] && !model_prev[i]) model_cnt[i] = model_cnt[i] + 12'd1;
	end
	model_prev  = lines;
	model_cycle = model_cycle + 1;
endtask

`endif

// File: sim/tb_cache_perf_monitor.sv
`default_nettype none

module tb_cache_perf_monitor;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned SAMPLE_FIRST  = 40;
	localparam int unsigned SAMPLE_PERIOD = 80;
	localparam int unsigned SAMPLE_COUNT  = 4;
	localparam int unsigned SEED          = 27968;
	localparam logic [7:0]  HOLD_PATTERN  = 8'b1010_0110;

	logic                    clk = 1'b0;
	logic                    rstn;
	perf_pkg::cache_events_t events;
	logic [31:0]             data;
	logic                    wr_en;

	int          word_errors  = 0;
	int          end_errors   = 0;
	int          timeouts     = 0;
	int          records_seen = 0;
	int          word_idx     = 0;
	logic [31:0] got_words [$];
	logic [31:0] exp_seen [$];

	`include "tb_model.svh"

	cache_perf_monitor #(
		.SAMPLE_FIRST  (SAMPLE_FIRST),
		.SAMPLE_PERIOD (SAMPLE_PERIOD),
		.SAMPLE_COUNT  (SAMPLE_COUNT)
	) UUT (
		.clk    (clk),
		.rstn   (rstn),
		.events (events),
		.data   (data),
		.wr_en  (wr_en)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected, inout int errors);
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, expected, actual, $time);
		end
	endtask

	// random lines or a steady hold until enough records have gone out
	task automatic run_until_records(input int target, input bit random_lines, input int limit);
		int          cycles;
		logic [31:0] rnd;
		cycles = 0;
		while (records_seen < target && cycles < limit) begin
			@(negedge clk);
			if (random_lines) begin
				rnd    = $urandom();
				events = rnd[7:0];
			end
			cycles++;
		end
		if (records_seen < target) begin
			timeouts++;
			$display("timed out after %0d cycles waiting for record %0d", cycles, target);
		end
	endtask

	task automatic hold_lines(input logic [7:0] pattern, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			events = pattern;
		end
	endtask

	// model steps on the same edges as the DUT
	always @(posedge clk) begin
		if (!rstn) begin
			reset_model();
		end else begin
			take_edge(events);
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		check_value("wr_en", 32'(wr_en), 32'(words_left != 0), word_errors);
		if (wr_en) begin
			if (exp_words.size() == 0) begin
				word_errors++;
				$display("a word was written while no record was expected at %0t", $time);
			end else begin
				exp_seen.push_back(exp_words[0]);
				check_value("data", data, exp_words.pop_front(), word_errors);
			end
			got_words.push_back(data);
			if (word_idx == 5) begin
				word_idx = 0;
				records_seen <= records_seen + 1;
			end else begin
				word_idx = word_idx + 1;
			end
		end else if (records_seen == 0 && word_idx == 0) begin
			check_value("data", data, 32'h0, word_errors);
		end
	end

	initial begin
		void'($urandom(SEED));
		rstn   = 1'b0;
		// lines already high when reset lifts
		events = '1;
		repeat (8) @(negedge clk);
		rstn = 1'b1;

		run_until_records(2, 1'b1, SAMPLE_FIRST + 2 * SAMPLE_PERIOD);

		// held lines, one drop in the middle gives one more edge each
		if (timeouts == 0) begin
			hold_lines(HOLD_PATTERN, 30);
			hold_lines(8'h00, 2);
			hold_lines(HOLD_PATTERN, 1);
			run_until_records(SAMPLE_COUNT, 1'b0, 3 * SAMPLE_PERIOD);
		end

		if (timeouts == 0) begin
			// no further records may start
			repeat (2 * SAMPLE_PERIOD) @(negedge clk);
			check_value("record word count", 32'(got_words.size()), 32'(6 * SAMPLE_COUNT),
				end_errors);
			check_value("expected queue size", 32'(exp_words.size()), 32'h0, end_errors);
			// no edges between the last two samples, so record 4 repeats record 3's counts
			if (got_words.size() == 24 && exp_seen.size() == 24) begin
				for (int i = 0; i < 6; i++) begin
					check_value($sformatf("data record 4 word %0d", i), got_words[18 + i],
						exp_seen[12 + i], end_errors);
				end
			end
		end

		$display("summary: %0d word errors, %0d end of run errors, %0d timeouts",
			word_errors, end_errors, timeouts);
		if (word_errors + end_errors + timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
src/perf_pkg.sv
src/event_counter_bank.sv
src/sample_timer.sv
src/record_serializer.sv
src/cache_perf_monitor.sv
sim/tb_cache_perf_monitor.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache performance monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
	-f all.f \
	--top-module tb_cache_perf_monitor \
	-o sim_cache_perf_monitor

./obj_dir/sim_cache_perf_monitor > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "testbench reported a failure, see sim.log"
	exit 1
fi

echo "testbench run finished without failure"
exit 0
